// ==== source/tcdm_pkg.sv ====
`default_nettype none

package tcdm_pkg;

  // one bank lane carries a single 32-bit word
  localparam int unsigned LANE_DW = 32;
  // one enable bit per byte of the lane
  localparam int unsigned LANE_BW = LANE_DW / 8;

  // byte address of the wide port
  localparam int unsigned ADDR_W = 32;

  // payload of one lane, used on both request and response side
  typedef logic [LANE_DW-1:0] lane_data_t;

  // byte enables of one lane
  typedef logic [LANE_BW-1:0] lane_be_t;

endpackage

`default_nettype wire

// ==== source/router_pkg.sv ====
`default_nettype none

package router_pkg;

  // upper bound for the bank index field, real bank count is a module parameter
  localparam int unsigned NB_BANKS_MAX_LOG = 4;

  // byte offset inside one 32-bit lane word
  localparam int unsigned BYTE_OFFS_W = $clog2(tcdm_pkg::LANE_BW);

  // whatever is left above the bank index
  localparam int unsigned ROW_FIELD_W = tcdm_pkg::ADDR_W - NB_BANKS_MAX_LOG - BYTE_OFFS_W;

  // bank index as it sits in the address
  typedef logic [NB_BANKS_MAX_LOG-1:0] bank_idx_t;

  // row address inside one bank
  typedef logic [tcdm_pkg::ADDR_W-1:0] bank_row_t;

  // word-interleaved view: row | bank index | byte offset
  typedef struct packed {
    logic [ROW_FIELD_W-1:0] row;
    bank_idx_t              idx;
    logic [BYTE_OFFS_W-1:0] offs;
  } wide_addr_fields_t;

  // raw byte address and its decoded view share one word
  typedef union packed {
    logic [tcdm_pkg::ADDR_W-1:0] raw;
    wide_addr_fields_t           f;
  } wide_addr_u;

endpackage

`default_nettype wire

// ==== source/tcdm_channel_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface tcdm_channel_if;

  // request side, driven by the initiator
  logic                  req;
  router_pkg::bank_row_t add;
  // 1 selects a read, 0 a write
  logic                  wen;
  tcdm_pkg::lane_be_t    be;
  tcdm_pkg::lane_data_t  data;

  // accepted when req and gnt are both high
  logic                  gnt;
  // r_valid one cycle after acceptance, r_data only meaningful for reads
  logic                  r_valid;
  tcdm_pkg::lane_data_t  r_data;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_valid, r_data
  );

endinterface

`default_nettype wire

// ==== source/req_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned WIDE_WORDS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     in_req_i,
  input  router_pkg::wide_addr_u                   in_add_i,
  input  logic                                     in_wen_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  in_be_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  in_data_i,
  output logic                                     in_gnt_o,
  output logic                                     out_req_o,
  output router_pkg::wide_addr_u                   out_add_o,
  output logic                                     out_wen_o,
  output logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  out_be_o,
  output logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  out_data_o,
  input  logic                                     out_gnt_i
);

  if (FIFO_DEPTH == 0) begin : gen_bypass
    // no storage, handshake goes straight through
    assign out_req_o  = in_req_i;
    assign out_add_o  = in_add_i;
    assign out_wen_o  = in_wen_i;
    assign out_be_o   = in_be_i;
    assign out_data_o = in_data_i;
    assign in_gnt_o   = out_gnt_i;
  end else begin : gen_fifo
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [tcdm_pkg::ADDR_W-1:0]              add_mem  [FIFO_DEPTH];
    logic                                     wen_mem  [FIFO_DEPTH];
    logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  be_mem   [FIFO_DEPTH];
    logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  data_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]                         wr_ptr_q;
    logic [PTR_W-1:0]                         rd_ptr_q;
    logic [CNT_W-1:0]                         cnt_q;
    logic [CNT_W-1:0]                         cnt_d;
    logic                                     room_q;
    logic                                     push;
    logic                                     pop;

    assign push  = in_req_i & room_q;
    assign pop   = out_req_o & out_gnt_i;
    assign cnt_d = cnt_q + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
        // no grant while in reset
        room_q   <= 1'b0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        cnt_q  <= cnt_d;
        // room for one more entry next cycle
        room_q <= (cnt_d < CNT_W'(FIFO_DEPTH));
      end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        add_mem[wr_ptr_q]  <= in_add_i.raw;
        wen_mem[wr_ptr_q]  <= in_wen_i;
        be_mem[wr_ptr_q]   <= in_be_i;
        data_mem[wr_ptr_q] <= in_data_i;
      end
    end

    assign in_gnt_o      = room_q;
    // head is valid as soon as one entry is stored
    assign out_req_o     = (cnt_q != '0);
    assign out_add_o.raw = add_mem[rd_ptr_q];
    assign out_wen_o     = wen_mem[rd_ptr_q];
    assign out_be_o      = be_mem[rd_ptr_q];
    assign out_data_o    = data_mem[rd_ptr_q];
  end

endmodule

`default_nettype wire

// ==== source/wide_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module wide_router #(
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned WIDE_WORDS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_i,
  input  router_pkg::wide_addr_u                   add_i,
  input  logic                                     wen_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  be_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  data_i,
  output logic                                     gnt_o,
  output logic                                     r_valid_o,
  output logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  r_data_o,
  output logic [$clog2(NB_BANKS)-1:0]              bank_offset_o,
  tcdm_channel_if.initiator                        lanes [WIDE_WORDS]
);

  localparam int unsigned BANK_LOG = $clog2(NB_BANKS);
  localparam int unsigned LANE_DW  = tcdm_pkg::LANE_DW;
  localparam int unsigned LANE_BW  = tcdm_pkg::LANE_BW;

  router_pkg::bank_row_t   base_row;
  logic [WIDE_WORDS-1:0]   lane_gnt;
  logic [WIDE_WORDS-1:0]   lane_r_valid;
  logic                    handshake_d;
  logic                    handshake_q;

  // bank of lane 0, index field masked to the configured bank count
  assign bank_offset_o = add_i.f.idx[BANK_LOG-1:0];

  // word address with the bank bits removed gives the row
  assign base_row = router_pkg::bank_row_t'({add_i.f.row, add_i.f.idx} >> BANK_LOG);

  for (genvar k = 0; k < WIDE_WORDS; k++) begin : gen_lane
    // every lane shares the wide request, no arbitration
    assign lanes[k].req  = req_i;
    assign lanes[k].wen  = wen_i;
    assign lanes[k].be   = be_i[k*LANE_BW +: LANE_BW];
    assign lanes[k].data = data_i[k*LANE_DW +: LANE_DW];

    // lanes running past the last bank wrap to bank 0 on the next row
    assign lanes[k].add = (int'(bank_offset_o) + k >= NB_BANKS) ? base_row + 1'b1 : base_row;

    assign lane_gnt[k]     = lanes[k].gnt;
    assign lane_r_valid[k] = lanes[k].r_valid;
    assign r_data_o[k*LANE_DW +: LANE_DW] = lanes[k].r_data;
  end

  // wide grant only when all targeted banks grant in the same cycle
  assign handshake_d = req_i & (&lane_gnt);
  assign gnt_o       = handshake_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      handshake_q <= 1'b0;
    end else begin
      handshake_q <= handshake_d;
    end
  end

  // partial grants leave handshake_q low, so their responses are dropped
  assign r_valid_o = handshake_q & (&lane_r_valid);

endmodule

`default_nettype wire

// ==== source/router_reorder.sv ====
`timescale 1ns/10ps
`default_nettype none

module router_reorder #(
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned WIDE_WORDS = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [$clog2(NB_BANKS)-1:0] order_i,
  tcdm_channel_if.target              lanes [WIDE_WORDS],
  tcdm_channel_if.initiator           banks [NB_BANKS]
);

  localparam int unsigned BANK_LOG = $clog2(NB_BANKS);
  localparam int unsigned LANE_LOG = (WIDE_WORDS > 1) ? $clog2(WIDE_WORDS) : 1;

  logic [BANK_LOG-1:0]   order_q;
  logic [WIDE_WORDS-1:0] lane_req;
  logic [WIDE_WORDS-1:0] lane_wen;
  router_pkg::bank_row_t lane_add  [WIDE_WORDS];
  tcdm_pkg::lane_be_t    lane_be   [WIDE_WORDS];
  tcdm_pkg::lane_data_t  lane_data [WIDE_WORDS];
  logic [NB_BANKS-1:0]   bank_gnt;
  logic [NB_BANKS-1:0]   bank_r_valid;
  tcdm_pkg::lane_data_t  bank_r_data [NB_BANKS];

  // responses come one cycle later, so they follow the offset of that cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else begin
      order_q <= order_i;
    end
  end

  for (genvar k = 0; k < WIDE_WORDS; k++) begin : gen_lane
    logic [BANK_LOG-1:0] req_bank;
    logic [BANK_LOG-1:0] resp_bank;

    assign lane_req[k]  = lanes[k].req;
    assign lane_wen[k]  = lanes[k].wen;
    assign lane_add[k]  = lanes[k].add;
    assign lane_be[k]   = lanes[k].be;
    assign lane_data[k] = lanes[k].data;

    // bank index wraps modulo NB_BANKS through the truncated sum
    assign req_bank  = order_i + BANK_LOG'(k);
    assign resp_bank = order_q + BANK_LOG'(k);

    assign lanes[k].gnt     = bank_gnt[req_bank];
    assign lanes[k].r_valid = bank_r_valid[resp_bank];
    assign lanes[k].r_data  = bank_r_data[resp_bank];
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    logic [BANK_LOG-1:0] lane_dist;
    logic [LANE_LOG-1:0] lane_sel;
    logic                hit;

    // distance from lane 0 bank, valid lane only when below WIDE_WORDS
    assign lane_dist = BANK_LOG'(b) - order_i;
    assign hit       = (lane_dist < WIDE_WORDS);
    assign lane_sel  = LANE_LOG'(lane_dist);

    // untargeted banks see no request
    assign banks[b].req  = hit & lane_req[lane_sel];
    assign banks[b].wen  = lane_wen[lane_sel];
    assign banks[b].add  = lane_add[lane_sel];
    assign banks[b].be   = lane_be[lane_sel];
    assign banks[b].data = lane_data[lane_sel];

    assign bank_gnt[b]     = banks[b].gnt;
    assign bank_r_valid[b] = banks[b].r_valid;
    assign bank_r_data[b]  = banks[b].r_data;
  end

endmodule

`default_nettype wire

// ==== source/tcdm_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BANK_ROWS = 64
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           busy_i,
  tcdm_channel_if.target port
);

  localparam int unsigned ROW_W   = (BANK_ROWS > 1) ? $clog2(BANK_ROWS) : 1;
  localparam int unsigned LANE_BW = tcdm_pkg::LANE_BW;

  tcdm_pkg::lane_data_t mem [BANK_ROWS];
  tcdm_pkg::lane_data_t r_data_q;
  logic [ROW_W-1:0]     row;
  logic                 access;
  logic                 r_valid_q;

  // row wraps inside the bank
  assign row = port.add[ROW_W-1:0];

  // busy stands for another user holding the bank
  assign access   = port.req & ~busy_i;
  assign port.gnt = access;

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (access && !port.wen) begin
      for (int i = 0; i < LANE_BW; i++) begin
        if (port.be[i]) begin
          mem[row][i*8 +: 8] <= port.data[i*8 +: 8];
        end
      end
    end
  end

  // read word captured on a granted read
  always_ff @(posedge clk_i) begin
    if (access && port.wen) begin
      r_data_q <= mem[row];
    end
  end

  // every granted access answers one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= access;
    end
  end

  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;

endmodule

`default_nettype wire

// ==== source/wide_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wide_mem_top #(
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned WIDE_WORDS = 4,
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned BANK_ROWS  = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     in_req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]              in_add_i,
  input  logic                                     in_wen_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  in_be_i,
  input  logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  in_data_i,
  output logic                                     in_gnt_o,
  output logic                                     in_r_valid_o,
  output logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  in_r_data_o,
  input  logic [NB_BANKS-1:0]                      bank_busy_i
);

  router_pkg::wide_addr_u                   in_add;
  logic                                     fifo_req;
  router_pkg::wide_addr_u                   fifo_add;
  logic                                     fifo_wen;
  logic [WIDE_WORDS*tcdm_pkg::LANE_BW-1:0]  fifo_be;
  logic [WIDE_WORDS*tcdm_pkg::LANE_DW-1:0]  fifo_data;
  logic                                     fifo_gnt;
  logic [$clog2(NB_BANKS)-1:0]              bank_offset;

  // lanes between router and reorder, banks between reorder and memories
  tcdm_channel_if lane_if [WIDE_WORDS] ();
  tcdm_channel_if bank_if [NB_BANKS] ();

  assign in_add.raw = in_add_i;

  req_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .WIDE_WORDS ( WIDE_WORDS )
  ) i_req_fifo (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .in_req_i   ( in_req_i  ),
    .in_add_i   ( in_add    ),
    .in_wen_i   ( in_wen_i  ),
    .in_be_i    ( in_be_i   ),
    .in_data_i  ( in_data_i ),
    .in_gnt_o   ( in_gnt_o  ),
    .out_req_o  ( fifo_req  ),
    .out_add_o  ( fifo_add  ),
    .out_wen_o  ( fifo_wen  ),
    .out_be_o   ( fifo_be   ),
    .out_data_o ( fifo_data ),
    .out_gnt_i  ( fifo_gnt  )
  );

  wide_router #(
    .NB_BANKS   ( NB_BANKS   ),
    .WIDE_WORDS ( WIDE_WORDS )
  ) i_wide_router (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .req_i         ( fifo_req     ),
    .add_i         ( fifo_add     ),
    .wen_i         ( fifo_wen     ),
    .be_i          ( fifo_be      ),
    .data_i        ( fifo_data    ),
    .gnt_o         ( fifo_gnt     ),
    .r_valid_o     ( in_r_valid_o ),
    .r_data_o      ( in_r_data_o  ),
    .bank_offset_o ( bank_offset  ),
    .lanes         ( lane_if      )
  );

  router_reorder #(
    .NB_BANKS   ( NB_BANKS   ),
    .WIDE_WORDS ( WIDE_WORDS )
  ) i_router_reorder (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .order_i ( bank_offset ),
    .lanes   ( lane_if     ),
    .banks   ( bank_if     )
  );

  // one 32-bit memory per bank, each with its own busy input
  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    tcdm_bank #(
      .BANK_ROWS ( BANK_ROWS )
    ) i_tcdm_bank (
      .clk_i  ( clk_i          ),
      .rst_ni ( rst_ni         ),
      .busy_i ( bank_busy_i[b] ),
      .port   ( bank_if[b]     )
    );
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_wide_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wide_mem;

  localparam int unsigned NB_BANKS   = 8;
  localparam int unsigned WIDE_WORDS = 4;
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned BANK_ROWS  = 64;
  localparam int unsigned DW         = WIDE_WORDS * 32;
  localparam int unsigned BW         = WIDE_WORDS * 4;
  localparam int unsigned WORDS      = NB_BANKS * BANK_ROWS;
  localparam int unsigned TIMEOUT    = 50;

  // one row of the stimulus table
  typedef struct {
    string          name;
    bit             rd;
    logic [31:0]    addr;
    logic [BW-1:0]  be;
    logic [DW-1:0]  data;
    bit             rnd;
    logic [NB_BANKS-1:0] busy;
    int             hold;
  } entry_t;

  // accepted request waiting for its response
  typedef struct {
    string               name;
    bit                  rd;
    logic [DW-1:0]       data;
    logic [NB_BANKS-1:0] banks;
  } expect_t;

  logic                clk;
  logic                rst_n;
  logic                in_req;
  logic [31:0]         in_add;
  logic                in_wen;
  logic [BW-1:0]       in_be;
  logic [DW-1:0]       in_data;
  logic                in_gnt;
  logic                in_r_valid;
  logic [DW-1:0]       in_r_data;
  logic [NB_BANKS-1:0] bank_busy;

  logic [31:0] shadow [WORDS];
  entry_t      stim [$];
  expect_t     pending [$];
  logic [31:0] rnd_state;
  int          busy_left;
  int          errors;
  int          resp_errors;
  int          timeouts;
  int          accepted;
  int          responses;
  bit          aborted;
  bit          saw_full;

  tb_clock_gen #(.RST_CYCLES(4)) i_clock_gen (.clk_o(clk), .rst_no(rst_n));

  wide_mem_top #(
    .NB_BANKS   ( NB_BANKS   ),
    .WIDE_WORDS ( WIDE_WORDS ),
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .BANK_ROWS  ( BANK_ROWS  )
  ) i_dut (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .in_req_i     ( in_req     ),
    .in_add_i     ( in_add     ),
    .in_wen_i     ( in_wen     ),
    .in_be_i      ( in_be      ),
    .in_data_i    ( in_data    ),
    .in_gnt_o     ( in_gnt     ),
    .in_r_valid_o ( in_r_valid ),
    .in_r_data_o  ( in_r_data  ),
    .bank_busy_i  ( bank_busy  )
  );

  // 32-bit xorshift with its state in rnd_state
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rnd_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rnd_state = x;
    return x;
  endfunction

  task automatic add_entry(input string name, input bit rd, input logic [31:0] addr,
                           input logic [BW-1:0] be, input logic [DW-1:0] data, input bit rnd,
                           input logic [NB_BANKS-1:0] busy, input int hold);
    entry_t e;
    e.name = name;
    e.rd   = rd;
    e.addr = addr;
    e.be   = be;
    e.data = data;
    e.rnd  = rnd;
    e.busy = busy;
    e.hold = hold;
    stim.push_back(e);
  endtask

  task automatic build_stim();
    // fill words 0..15 with full aligned writes
    add_entry("fill0",    0, 32'h00, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("fill1",    0, 32'h10, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("fill2",    0, 32'h20, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("fill3",    0, 32'h30, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("align_wr", 0, 32'h00, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("align_rd", 1, 32'h00, 16'hffff, '0, 0, 8'h00, 0);
    // offsets 5..7 push the upper lanes onto row 1
    add_entry("wrap5_wr", 0, 32'h14, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("wrap5_rd", 1, 32'h14, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("wrap6_wr", 0, 32'h18, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("wrap6_rd", 1, 32'h18, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("wrap7_wr", 0, 32'h1c, 16'hffff, '0, 1, 8'h00, 0);
    add_entry("wrap7_rd", 1, 32'h1c, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("next_rd",  1, 32'h20, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("be_wr",    0, 32'h30, 16'h5a3c,
              128'h0123456789abcdef_fedcba9876543210, 0, 8'h00, 0);
    add_entry("be_rd",    1, 32'h30, 16'hffff, '0, 0, 8'h00, 0);
    // bank 2 held busy while the fifo fills behind the write
    add_entry("busy_wr",  0, 32'h40, 16'hffff, '0, 1, 8'h04, 12);
    add_entry("busy_rd0", 1, 32'h40, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("busy_rd1", 1, 32'h00, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("busy_rd2", 1, 32'h14, 16'hffff, '0, 0, 8'h00, 0);
    // back-to-back reads
    add_entry("burst0",   1, 32'h00, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("burst1",   1, 32'h04, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("burst2",   1, 32'h08, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("burst3",   1, 32'h24, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("burst4",   1, 32'h30, 16'hffff, '0, 0, 8'h00, 0);
    add_entry("burst5",   1, 32'h40, 16'hffff, '0, 0, 8'h00, 0);
  endtask

  // the busy mask counts down on each rising edge
  task automatic next_edge();
    @(posedge clk);
    if (busy_left > 0) begin
      busy_left--;
      if (busy_left == 0) begin
        bank_busy <= '0;
      end
    end
  endtask

  // grant sampled on the falling edge and taken on the next rising edge
  task automatic wait_grant(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++) begin
      @(negedge clk);
      ok = in_gnt;
      if (!in_gnt && bank_busy != '0) begin
        saw_full = 1'b1;
      end
      next_edge();
    end
  endtask

  // lane k of byte address A sits at word A/4+k in bank word%8
  task automatic record_accept(input entry_t e, input logic [DW-1:0] data);
    expect_t     x;
    int unsigned w;
    int          k;
    int          b;
    x.name  = e.name;
    x.rd    = e.rd;
    x.data  = '0;
    x.banks = '0;
    for (k = 0; k < WIDE_WORDS; k++) begin
      w = ((e.addr >> 2) + k) % WORDS;
      x.banks[w % NB_BANKS] = 1'b1;
      if (e.rd) begin
        x.data[k*32 +: 32] = shadow[w];
      end else begin
        for (b = 0; b < 4; b++) begin
          if (e.be[k*4 + b]) begin
            shadow[w][b*8 +: 8] = data[k*32 + b*8 +: 8];
          end
        end
      end
    end
    pending.push_back(x);
    accepted++;
  endtask

  task automatic apply_entry(input entry_t e);
    logic [DW-1:0] data;
    bit            ok;
    data = e.rnd ? {next_random(), next_random(), next_random(), next_random()} : e.data;
    in_req  <= 1'b1;
    in_add  <= e.addr;
    in_wen  <= e.rd;
    in_be   <= e.be;
    in_data <= data;
    if (e.hold > 0) begin
      bank_busy <= e.busy;
      busy_left = e.hold;
    end
    wait_grant(ok);
    if (ok) begin
      record_accept(e, data);
    end else begin
      timeouts++;
      $display("timeout: request %s was never granted", e.name);
      aborted = 1'b1;
    end
  endtask

  // response monitor checks in request order
  always @(negedge clk) begin
    expect_t x;
    if (rst_n && in_r_valid) begin
      responses++;
      assert (pending.size() > 0) else begin
        resp_errors++;
        $display("response arrived with no request pending");
      end
      if (pending.size() > 0) begin
        x = pending.pop_front();
        assert ((bank_busy & x.banks) == '0) else begin
          resp_errors++;
          $display("%s answered while a targeted bank was still busy", x.name);
        end
        if (x.rd) begin
          assert (in_r_data === x.data) else begin
            resp_errors++;
            $display("error: %s expected %h actual %h", x.name, x.data, in_r_data);
          end
        end
      end
    end
  end

  initial begin
    int n;
    int i;
    in_req      = 1'b0;
    in_add      = '0;
    in_wen      = 1'b0;
    in_be       = '0;
    in_data     = '0;
    bank_busy   = '0;
    rnd_state   = 32'd7556;
    busy_left   = 0;
    errors      = 0;
    resp_errors = 0;
    timeouts    = 0;
    accepted    = 0;
    responses   = 0;
    aborted     = 1'b0;
    saw_full    = 1'b0;
    build_stim();

    // outputs idle while reset is held
    @(posedge clk);
    for (n = 0; n < TIMEOUT && !rst_n; n++) begin
      @(negedge clk);
      if (!rst_n) begin
        assert (!in_gnt && !in_r_valid) else begin
          errors++;
          $display("grant or response valid high during reset");
        end
      end
    end
    if (!rst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
      aborted = 1'b1;
    end
    @(negedge clk);
    assert (!in_r_valid) else begin
      errors++;
      $display("response valid high right after reset");
    end
    next_edge();

    for (i = 0; i < stim.size() && !aborted; i++) begin
      apply_entry(stim[i]);
    end
    in_req <= 1'b0;

    // drain outstanding responses
    for (n = 0; n < 4 * TIMEOUT && pending.size() > 0 && !aborted; n++) begin
      @(negedge clk);
    end
    if (pending.size() > 0) begin
      timeouts++;
      $display("timeout: %0d responses never arrived", pending.size());
    end
    // late duplicates would show up here
    repeat (5) @(negedge clk);
    assert (responses == accepted) else begin
      errors++;
      $display("error: response count expected %0d actual %0d", accepted, responses);
    end
    assert (saw_full) else begin
      errors++;
      $display("grant never dropped while a bank was busy");
    end

    $display("accepted %0d, responses %0d, errors %0d, timeouts %0d",
             accepted, responses, errors + resp_errors, timeouts);
    if (errors + resp_errors + timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/tcdm_pkg.sv
source/router_pkg.sv
source/tcdm_channel_if.sv
source/req_fifo.sv
source/wide_router.sv
source/router_reorder.sv
source/tcdm_bank.sv
source/wide_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_wide_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict taken from the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wide_mem -f flist.f -o sim_tb_wide_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_wide_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
